/* files.f */
rtl/aud_pkg.sv
rtl/aud_ctrl.sv
rtl/aud_recorder.sv
rtl/aud_player.sv
rtl/aud_sram_port.sv
rtl/aud_top.sv
verif/aud_properties.sv
verif/aud_tb.sv

/* rtl/aud_ctrl.sv */
`timescale 1ns/100ps

module aud_ctrl (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_key_rec,
    input  logic                i_key_play,
    input  logic                i_key_pause,
    input  logic                i_key_stop,
    input  logic                i_rec_done,
    input  logic                i_play_done,
    output logic                o_rec_start,
    output logic                o_play_start,
    output logic                o_pause,
    output logic                o_stop,
    output aud_pkg::aud_mode_e  o_mode,
    output logic                o_finish
);
    import aud_pkg::*;

    logic [3:0] keys;
    logic [3:0] key_r;
    logic [3:0] key_edge;

    aud_mode_e  mode_r, mode_w;
    logic       rec_start_r, rec_start_w;
    logic       play_start_r, play_start_w;
    logic       pause_r, pause_w;
    logic       stop_r, stop_w;
    logic       finish_r, finish_w;

    assign keys     = {i_key_rec, i_key_play, i_key_pause, i_key_stop};
    assign key_edge = keys & ~key_r;                         // Rec, play, pause, stop

    assign o_rec_start  = rec_start_r;
    assign o_play_start = play_start_r;
    assign o_pause      = pause_r;
    assign o_stop       = stop_r;
    assign o_mode       = mode_r;
    assign o_finish     = finish_r;

    always_comb begin
        mode_w       = mode_r;
        rec_start_w  = 1'b0;
        play_start_w = 1'b0;
        pause_w      = 1'b0;
        stop_w       = 1'b0;
        finish_w     = 1'b0;
        case (mode_r)
            MODE_IDLE: begin
                if (key_edge[3]) begin                       // Record wins over play
                    mode_w      = MODE_REC;
                    rec_start_w = 1'b1;
                end else if (key_edge[2]) begin
                    mode_w       = MODE_PLAY;
                    play_start_w = 1'b1;
                end
            end
            MODE_REC, MODE_PLAY: begin
                pause_w = key_edge[1];
                stop_w  = key_edge[0];
                if ((mode_r == MODE_REC && i_rec_done) || (mode_r == MODE_PLAY && i_play_done)) begin
                    mode_w   = MODE_IDLE;
                    finish_w = 1'b1;
                end
            end
            default: mode_w = MODE_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            key_r        <= '0;
            mode_r       <= MODE_IDLE;
            rec_start_r  <= 1'b0;
            play_start_r <= 1'b0;
            pause_r      <= 1'b0;
            stop_r       <= 1'b0;
            finish_r     <= 1'b0;
        end else begin
            key_r        <= keys;
            mode_r       <= mode_w;
            rec_start_r  <= rec_start_w;
            play_start_r <= play_start_w;
            pause_r      <= pause_w;
            stop_r       <= stop_w;
            finish_r     <= finish_w;
        end
    end

endmodule

/* rtl/aud_pkg.sv */
package aud_pkg;

    // ******************************************************************
    // Widths and limits
    // ******************************************************************
    localparam int AUD_SAMPLE_W  = 16;
    localparam int AUD_ADDR_W    = 20;
    localparam int AUD_MAX_WORDS = 1024000;                  // Default recording limit
    localparam int AUD_BIT_CNT_W = $clog2(AUD_SAMPLE_W);     // Bit index within a sample

    typedef logic [AUD_SAMPLE_W-1:0]  aud_sample_t;
    typedef logic [AUD_ADDR_W-1:0]    aud_addr_t;            // Word address or word count
    typedef logic [AUD_BIT_CNT_W-1:0] aud_bitcnt_t;

    // ******************************************************************
    // SRAM requests
    // ******************************************************************
    typedef struct packed {
        logic        valid;
        aud_addr_t   addr;
        aud_sample_t data;
    } aud_wr_t;

    typedef struct packed {
        logic      en;
        aud_addr_t addr;
    } aud_rd_t;

    // ******************************************************************
    // State machines
    // ******************************************************************
    typedef enum logic [1:0] {
        MODE_IDLE,
        MODE_REC,
        MODE_PLAY
    } aud_mode_e;

    typedef enum logic [2:0] {
        REC_IDLE,
        REC_WAIT,
        REC_CAPTURE,
        REC_PAUSED,
        REC_FINISH
    } rec_state_e;

    typedef enum logic [2:0] {
        PLAY_IDLE,
        PLAY_FETCH,
        PLAY_SHIFT,
        PLAY_PAUSED,
        PLAY_FINISH
    } play_state_e;

endpackage

/* rtl/aud_player.sv */
`timescale 1ns/100ps

module aud_player (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_lrc,
    input  logic                 i_start,
    input  logic                 i_pause,
    input  logic                 i_stop,
    input  aud_pkg::aud_sample_t i_rd_data,
    input  aud_pkg::aud_addr_t   i_rec_count,
    output aud_pkg::aud_rd_t     o_rd,
    output logic                 o_dacdat,
    output logic                 o_done
);
    import aud_pkg::*;

    play_state_e state_r, state_w;
    aud_addr_t   addr_r, addr_w;
    aud_bitcnt_t bit_cnt_r, bit_cnt_w;
    logic        pause_req_r, pause_req_w;
    logic        done_r, done_w;
    aud_sample_t sample_r;

    aud_addr_t   addr_next;
    logic        active;
    logic        fetch_en;
    logic        send;

    assign active    = (state_r == PLAY_FETCH) || (state_r == PLAY_SHIFT) ||
                       (state_r == PLAY_PAUSED);
    assign addr_next = addr_r + 1'b1;
    assign fetch_en  = (state_r == PLAY_FETCH) && i_lrc && !pause_req_r;
    assign send      = (state_r == PLAY_SHIFT) && !i_lrc;    // Left half, word in flight

    assign o_rd     = '{en: fetch_en, addr: addr_r};
    assign o_dacdat = send & sample_r[AUD_SAMPLE_W-1];
    assign o_done   = done_r;

    always_comb begin
        state_w     = state_r;
        addr_w      = addr_r;
        bit_cnt_w   = bit_cnt_r;
        pause_req_w = pause_req_r ^ (active & i_pause);
        done_w      = 1'b0;
        case (state_r)
            PLAY_IDLE: begin
                if (i_start) begin
                    addr_w      = '0;
                    pause_req_w = 1'b0;
                    if (i_rec_count == '0) begin             // Nothing recorded
                        state_w = PLAY_FINISH;
                        done_w  = 1'b1;
                    end else begin
                        state_w = PLAY_FETCH;
                    end
                end
            end
            PLAY_FETCH: begin
                if (pause_req_r) begin
                    state_w = PLAY_PAUSED;
                end else if (fetch_en) begin
                    state_w   = PLAY_SHIFT;
                    bit_cnt_w = '0;
                end
            end
            PLAY_SHIFT: begin
                if (send) begin
                    bit_cnt_w = bit_cnt_r + 1'b1;
                    if (bit_cnt_r == aud_bitcnt_t'(AUD_SAMPLE_W - 1)) begin
                        addr_w = addr_next;
                        if (addr_next == i_rec_count) begin
                            state_w = PLAY_FINISH;
                            done_w  = 1'b1;
                        end else begin
                            state_w = PLAY_FETCH;
                        end
                    end
                end
            end
            PLAY_PAUSED: if (!pause_req_r) state_w = PLAY_FETCH;
            PLAY_FINISH: state_w = PLAY_IDLE;
            default:     state_w = PLAY_IDLE;
        endcase

        if (active && i_stop) begin
            state_w = PLAY_FINISH;
            done_w  = 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            state_r     <= PLAY_IDLE;
            addr_r      <= '0;
            bit_cnt_r   <= '0;
            pause_req_r <= 1'b0;
            done_r      <= 1'b0;
        end else begin
            state_r     <= state_w;
            addr_r      <= addr_w;
            bit_cnt_r   <= bit_cnt_w;
            pause_req_r <= pause_req_w;
            done_r      <= done_w;
        end
    end

    always_ff @(posedge i_clk) begin
        if (fetch_en) begin
            sample_r <= i_rd_data;                           // Async read settles in cycle
        end else if (send) begin
            sample_r <= {sample_r[AUD_SAMPLE_W-2:0], 1'b0};
        end
    end

endmodule

/* rtl/aud_recorder.sv */
`timescale 1ns/100ps

module aud_recorder #(
    parameter int P_MAX_WORDS = aud_pkg::AUD_MAX_WORDS
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_lrc,
    input  logic              i_adcdat,
    input  logic              i_start,
    input  logic              i_pause,
    input  logic              i_stop,
    output aud_pkg::aud_wr_t  o_wr,
    output logic              o_done
);
    import aud_pkg::*;

    rec_state_e  state_r, state_w;
    aud_addr_t   addr_r, addr_w;
    aud_bitcnt_t bit_cnt_r, bit_cnt_w;
    logic        pause_req_r, pause_req_w;
    logic        valid_r, valid_w;
    logic        done_r, done_w;
    logic        lrc_q_r;
    aud_sample_t shift_r;

    logic        shift_en;
    logic        active;
    logic        boundary;
    logic        pause_next;
    logic        limit_hit;

    assign active     = (state_r == REC_WAIT) || (state_r == REC_CAPTURE) ||
                        (state_r == REC_PAUSED);
    assign boundary   = lrc_q_r & ~i_lrc;                    // First cycle of left half
    assign pause_next = pause_req_r ^ (active & i_pause);
    assign limit_hit  = valid_r && (addr_r == aud_addr_t'(P_MAX_WORDS - 1));

    assign o_wr   = '{valid: valid_r, addr: addr_r, data: shift_r};
    assign o_done = done_r;

    always_comb begin
        state_w     = state_r;
        addr_w      = valid_r ? addr_r + 1'b1 : addr_r;      // Advance after each write
        bit_cnt_w   = bit_cnt_r;
        pause_req_w = pause_next;
        valid_w     = 1'b0;
        done_w      = 1'b0;
        shift_en    = 1'b0;
        case (state_r)
            REC_IDLE: begin
                if (i_start) begin
                    state_w     = REC_WAIT;
                    addr_w      = '0;
                    bit_cnt_w   = '0;
                    pause_req_w = 1'b0;
                end
            end
            REC_WAIT, REC_PAUSED: begin
                if (boundary) begin
                    if (pause_next) begin
                        state_w = REC_PAUSED;                // Skip this frame
                    end else begin
                        shift_en  = 1'b1;                    // MSB
                        bit_cnt_w = aud_bitcnt_t'(1);
                        state_w   = REC_CAPTURE;
                    end
                end
            end
            REC_CAPTURE: begin
                shift_en  = 1'b1;
                bit_cnt_w = bit_cnt_r + 1'b1;
                if (bit_cnt_r == aud_bitcnt_t'(AUD_SAMPLE_W - 1)) begin
                    valid_w   = 1'b1;
                    bit_cnt_w = '0;
                    state_w   = REC_WAIT;
                end
            end
            REC_FINISH: state_w = REC_IDLE;
            default:    state_w = REC_IDLE;
        endcase

        // Stop drops a partial frame, limit ends after the last write
        if (active && (i_stop || limit_hit)) begin
            state_w = REC_FINISH;
            valid_w = 1'b0;
            done_w  = 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            state_r     <= REC_IDLE;
            addr_r      <= '0;
            bit_cnt_r   <= '0;
            pause_req_r <= 1'b0;
            valid_r     <= 1'b0;
            done_r      <= 1'b0;
            lrc_q_r     <= 1'b0;
        end else begin
            state_r     <= state_w;
            addr_r      <= addr_w;
            bit_cnt_r   <= bit_cnt_w;
            pause_req_r <= pause_req_w;
            valid_r     <= valid_w;
            done_r      <= done_w;
            lrc_q_r     <= i_lrc;
        end
    end

    always_ff @(posedge i_clk) begin
        if (shift_en) begin
            shift_r <= {shift_r[AUD_SAMPLE_W-2:0], i_adcdat};
        end
    end

endmodule

/* rtl/aud_sram_port.sv */
`timescale 1ns/100ps

module aud_sram_port (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  aud_pkg::aud_mode_e   i_mode,
    input  aud_pkg::aud_wr_t     i_wr,
    input  aud_pkg::aud_rd_t     i_rd,
    input  aud_pkg::aud_sample_t i_sram_rdata,
    output aud_pkg::aud_addr_t   o_sram_addr,
    output aud_pkg::aud_sample_t o_sram_wdata,
    output logic                 o_sram_we_n,
    output logic                 o_sram_oe_n,
    output aud_pkg::aud_sample_t o_rd_data,
    output aud_pkg::aud_addr_t   o_rec_count
);
    import aud_pkg::*;

    aud_mode_e mode_q_r;
    aud_addr_t count_r;

    // ******************************************************************
    // Pin side
    // ******************************************************************
    always_comb begin
        case (i_mode)
            MODE_REC:  o_sram_addr = i_wr.addr;
            MODE_PLAY: o_sram_addr = i_rd.addr;
            default:   o_sram_addr = '0;
        endcase
    end

    assign o_sram_wdata = i_wr.data;
    assign o_sram_we_n  = ~i_wr.valid;
    assign o_sram_oe_n  = ~i_rd.en;
    assign o_rd_data    = i_sram_rdata;

    // ******************************************************************
    // Recorded length, kept through idle for a later play
    // ******************************************************************
    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            mode_q_r <= MODE_IDLE;
            count_r  <= '0;
        end else begin
            mode_q_r <= i_mode;
            if (i_mode == MODE_REC && mode_q_r != MODE_REC) begin
                count_r <= '0;                               // New recording
            end else if (i_wr.valid) begin
                count_r <= i_wr.addr + 1'b1;
            end
        end
    end

    assign o_rec_count = count_r;

endmodule

/* rtl/aud_top.sv */
`timescale 1ns/100ps

module aud_top #(
    parameter int P_MAX_WORDS = aud_pkg::AUD_MAX_WORDS
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_lrc,
    input  logic                 i_adcdat,
    input  logic                 i_key_rec,
    input  logic                 i_key_play,
    input  logic                 i_key_pause,
    input  logic                 i_key_stop,
    output logic                 o_dacdat,
    output logic                 o_finish,
    output aud_pkg::aud_addr_t   o_sram_addr,
    output aud_pkg::aud_sample_t o_sram_wdata,
    output logic                 o_sram_we_n,
    output logic                 o_sram_oe_n,
    input  aud_pkg::aud_sample_t i_sram_rdata
);
    import aud_pkg::*;

    logic        rec_start, play_start, pause, stop;
    logic        rec_done, play_done;
    aud_mode_e   mode;
    aud_wr_t     wr;
    aud_rd_t     rd;
    aud_sample_t rd_data;
    aud_addr_t   rec_count;

    aud_ctrl ctrl0 (
        .i_clk, .i_rst_n, .i_key_rec, .i_key_play, .i_key_pause, .i_key_stop,
        .i_rec_done(rec_done), .i_play_done(play_done),
        .o_rec_start(rec_start), .o_play_start(play_start),
        .o_pause(pause), .o_stop(stop), .o_mode(mode), .o_finish
    );

    aud_recorder #(.P_MAX_WORDS(P_MAX_WORDS)) rec0 (
        .i_clk, .i_rst_n, .i_lrc, .i_adcdat,
        .i_start(rec_start), .i_pause(pause), .i_stop(stop),
        .o_wr(wr), .o_done(rec_done)
    );

    aud_player play0 (
        .i_clk, .i_rst_n, .i_lrc,
        .i_start(play_start), .i_pause(pause), .i_stop(stop),
        .i_rd_data(rd_data), .i_rec_count(rec_count),
        .o_rd(rd), .o_dacdat, .o_done(play_done)
    );

    aud_sram_port sram0 (
        .i_clk, .i_rst_n, .i_mode(mode), .i_wr(wr), .i_rd(rd), .i_sram_rdata,
        .o_sram_addr, .o_sram_wdata, .o_sram_we_n, .o_sram_oe_n,
        .o_rd_data(rd_data), .o_rec_count(rec_count)
    );

endmodule

/* verif/aud_properties.sv */
`timescale 1ns/100ps

module aud_properties (
    input logic               i_clk,
    input logic               i_rst_n,
    input aud_pkg::aud_mode_e i_mode,
    input logic               i_sram_we_n,
    input logic               i_sram_oe_n
);
    import aud_pkg::*;

    // **********************************************************************
    // SRAM strobes
    // **********************************************************************
    strobes_exclusive: assert property (
        @(posedge i_clk) disable iff (i_rst_n)
        !(!i_sram_we_n && !i_sram_oe_n)
    ) else $error("SRAM write enable and output enable are low in the same cycle");

    write_in_record: assert property (
        @(posedge i_clk) disable iff (i_rst_n)
        !i_sram_we_n |-> (i_mode == MODE_REC)
    ) else $error("SRAM write enable is low outside the record mode");

    read_in_play: assert property (
        @(posedge i_clk) disable iff (i_rst_n)
        !i_sram_oe_n |-> (i_mode == MODE_PLAY)
    ) else $error("SRAM output enable is low outside the play mode");

    // Reset state of the pins
    strobes_idle_after_reset: assert property (
        @(posedge i_clk)
        i_rst_n |=> (i_sram_we_n && i_sram_oe_n)
    ) else $error("SRAM strobes are not high in the cycle after reset");

endmodule

/* verif/aud_tb.sv */
`timescale 1ns/100ps

module aud_tb;
    import aud_pkg::*;

    localparam int MAX_WORDS      = 32;
    localparam int FRAME_LEN      = 48;
    localparam int HALF           = FRAME_LEN / 2;
    localparam int LEFT_END       = HALF + AUD_SAMPLE_W;   // First phase after the sample
    localparam int MEM_DEPTH      = 64;
    localparam int MEM_AW         = $clog2(MEM_DEPTH);
    localparam int TIMEOUT_CYCLES = 120 * FRAME_LEN + 200;
    localparam int KEY_REC        = 0;
    localparam int KEY_PLAY       = 1;
    localparam int KEY_PAUSE      = 2;
    localparam int KEY_STOP       = 3;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_lrc;
    logic        i_adcdat;
    logic        i_key_rec;
    logic        i_key_play;
    logic        i_key_pause;
    logic        i_key_stop;
    logic        o_dacdat;
    logic        o_finish;
    aud_addr_t   o_sram_addr;
    aud_sample_t o_sram_wdata;
    logic        o_sram_we_n;
    logic        o_sram_oe_n;
    aud_sample_t i_sram_rdata;

    aud_sample_t             sram_mem [MEM_DEPTH];
    aud_sample_t             exp_wr_q [$];               // Frames still to be written
    aud_sample_t             exp_image [$];              // Current recording by address
    logic [AUD_SAMPLE_W-1:0] frame_bits;                 // Bits in arrival order
    aud_sample_t             dac_word;
    int                      phase;                      // Frame position of the pins
    int                      cycle_count;
    int                      wr_index;
    int                      rec_words;
    int                      play_idx;
    int                      finish_count;
    logic                    rec_active, rec_paused, frame_rec;
    logic                    play_active, play_paused, play_ok0, dac_carry;
    logic                    we_low_prev, finish_prev;

    aud_top #(.P_MAX_WORDS(MAX_WORDS)) dut0 (.*);

    bind aud_sram_port aud_properties props0 (
        .i_clk,
        .i_rst_n,
        .i_mode,
        .i_sram_we_n(o_sram_we_n),
        .i_sram_oe_n(o_sram_oe_n)
    );

    always #2 i_clk = ~i_clk;

    // **********************************************************************
    // Reference and error reporting
    // **********************************************************************
    function automatic aud_sample_t assemble_word(input logic [AUD_SAMPLE_W-1:0] bits);
        aud_sample_t word;
        for (int i = 0; i < AUD_SAMPLE_W; i++) begin
            word[AUD_SAMPLE_W-1-i] = bits[i];            // First bit is the MSB
        end
        return word;
    endfunction

    task automatic protocol_error(input string msg);
        $display("ERROR: %s", msg);
        $display("Test failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] got);
        $display("CHECK FAILED %s: expected 0x%0h, got 0x%0h", name, exp, got);
        $display("Test failed");
        $fatal(1, "Stopped at the first error");
    endtask

    // **********************************************************************
    // SRAM and codec models
    // **********************************************************************
    assign i_sram_rdata = sram_mem[o_sram_addr[MEM_AW-1:0]];

    always @(posedge i_clk) begin
        if (!o_sram_we_n) begin
            sram_mem[o_sram_addr[MEM_AW-1:0]] <= o_sram_wdata;
        end
    end

    initial begin
        int   nxt;
        logic bit_val;
        void'($urandom(84553));
        forever begin
            @(posedge i_clk);
            nxt = (phase + 1) % FRAME_LEN;
            phase    <= nxt;
            i_lrc    <= (nxt < HALF);
            i_adcdat <= 1'b0;
            if (nxt >= HALF && nxt < LEFT_END) begin
                bit_val = ($urandom % 2) != 0;
                frame_bits[nxt - HALF] = bit_val;
                i_adcdat <= bit_val;
            end
            if (nxt == HALF) begin
                frame_rec = rec_active && !rec_paused;   // Pause acts at the boundary
            end
            if (nxt == LEFT_END && frame_rec && rec_active) begin
                exp_wr_q.push_back(assemble_word(frame_bits));
                exp_image.push_back(assemble_word(frame_bits));
                rec_words++;
                if (rec_words == MAX_WORDS) begin
                    rec_active = 1'b0;                   // Word limit reached
                end
            end
            // A word may be fetched anywhere in the high half
            if (nxt == 0) begin
                play_ok0 = play_active && !play_paused;
            end
            if (nxt == HALF - 4) begin
                dac_carry = play_ok0 || (play_active && !play_paused);
                if (dac_carry) begin
                    dac_word = exp_image[play_idx];
                end
            end
            if (nxt == LEFT_END && dac_carry) begin
                dac_carry = 1'b0;
                play_idx++;
                if (play_idx == exp_image.size()) begin
                    play_active = 1'b0;
                end
            end
        end
    end

    // **********************************************************************
    // Checker
    // **********************************************************************
    always @(negedge i_clk) begin
        aud_sample_t exp_word;
        logic        exp_dac;
        if (!i_rst_n) begin
            if (!o_sram_we_n) begin
                assert (!we_low_prev)
                    else protocol_error("SRAM write strobe stayed low for two cycles");
                assert (phase == LEFT_END)
                    else protocol_error("SRAM write not in the cycle after the sixteenth bit");
                assert (exp_wr_q.size() > 0)
                    else protocol_error("SRAM write without a completed frame to record");
                exp_word = exp_wr_q.pop_front();
                assert (o_sram_addr == aud_addr_t'(wr_index))
                    else value_mismatch("o_sram_addr", wr_index, o_sram_addr);
                assert (o_sram_wdata == exp_word)
                    else value_mismatch("o_sram_wdata", exp_word, o_sram_wdata);
                wr_index++;
            end
            if (!o_sram_oe_n) begin
                assert (o_sram_addr == aud_addr_t'(play_idx))
                    else value_mismatch("o_sram_addr", play_idx, o_sram_addr);
            end
            if (o_finish) begin
                assert (!finish_prev)
                    else protocol_error("o_finish stayed high for two cycles");
                finish_count++;
            end
            exp_dac = 1'b0;
            if (dac_carry && phase >= HALF && phase < LEFT_END) begin
                exp_dac = dac_word[LEFT_END - 1 - phase];
            end
            assert (o_dacdat === exp_dac)
                else value_mismatch("o_dacdat", exp_dac, o_dacdat);
        end
        we_low_prev = !o_sram_we_n;
        finish_prev = o_finish;
    end

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            protocol_error("timeout, the tests did not reach their end in time");
        end
    end

    // **********************************************************************
    // Stimulus
    // **********************************************************************
    task automatic wait_phase(input int p);
        do begin
            @(posedge i_clk);
        end while (phase != (p + FRAME_LEN - 1) % FRAME_LEN);
    endtask

    task automatic set_key(input int key, input logic level);
        case (key)
            KEY_REC:   i_key_rec   <= level;
            KEY_PLAY:  i_key_play  <= level;
            KEY_PAUSE: i_key_pause <= level;
            default:   i_key_stop  <= level;
        endcase
    endtask

    task automatic press_key(input int key, input int p);
        wait_phase(p);
        set_key(key, 1'b1);
        repeat (3) @(posedge i_clk);                     // Key held as a level
        set_key(key, 1'b0);
    endtask

    task automatic wait_finish();
        int start_count;
        start_count = finish_count;
        while (finish_count == start_count) begin
            @(posedge i_clk);
        end
        repeat (8) @(posedge i_clk);
        assert (finish_count == start_count + 1)
            else value_mismatch("o_finish pulses", start_count + 1, finish_count);
    endtask

    task automatic start_recording();
        press_key(KEY_REC, 4);
        exp_image.delete();
        wr_index   = 0;
        rec_words  = 0;
        rec_paused = 1'b0;
        rec_active = 1'b1;
    endtask

    task automatic check_recording();
        wait_finish();
        assert (exp_wr_q.size() == 0)
            else protocol_error("a completed frame was never written to the SRAM");
        assert (dut0.rec_count == aud_addr_t'(exp_image.size()))
            else value_mismatch("rec_count", exp_image.size(), dut0.rec_count);
        foreach (exp_image[i]) begin
            assert (sram_mem[i] == exp_image[i])
                else value_mismatch("sram_mem", exp_image[i], sram_mem[i]);
        end
    endtask

    initial begin
        i_clk       = 1'b0;
        i_rst_n     = 1'b1;
        i_lrc       = 1'b1;
        i_adcdat    = 1'b0;
        i_key_rec   = 1'b0;
        i_key_play  = 1'b0;
        i_key_pause = 1'b0;
        i_key_stop  = 1'b0;
        phase       = 0;
        cycle_count = 0;
        wr_index    = 0;
        rec_words   = 0;
        play_idx    = 0;
        finish_count = 0;
        {rec_active, rec_paused, frame_rec} = '0;
        {play_active, play_paused, play_ok0, dac_carry} = '0;
        {we_low_prev, finish_prev} = '0;
        dac_word    = '0;
        frame_bits  = '0;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            sram_mem[i] = aud_sample_t'(i) ^ 16'hA5A5;
        end
        repeat (4) @(posedge i_clk);
        i_rst_n <= 1'b0;

        // Ten frames, then stop
        start_recording();
        repeat (9) wait_phase(4);
        press_key(KEY_STOP, 4);
        rec_active = 1'b0;
        check_recording();

        // Three frames skipped by a pause
        start_recording();
        repeat (2) wait_phase(4);
        press_key(KEY_PAUSE, 4);
        rec_paused = 1'b1;
        repeat (2) wait_phase(4);
        press_key(KEY_PAUSE, 4);
        rec_paused = 1'b0;
        repeat (2) wait_phase(4);
        press_key(KEY_STOP, 4);
        rec_active = 1'b0;
        check_recording();

        // Stop in the middle of the fifth frame
        start_recording();
        repeat (4) wait_phase(4);
        press_key(KEY_STOP, HALF + 6);
        rec_active = 1'b0;
        check_recording();

        // Run into the word limit
        start_recording();
        check_recording();
        assert (wr_index == MAX_WORDS)
            else value_mismatch("write count", MAX_WORDS, wr_index);

        // Playback with a pause of two frames
        press_key(KEY_PLAY, 4);
        play_idx    = 0;
        play_paused = 1'b0;
        play_active = 1'b1;
        repeat (4) wait_phase(4);
        press_key(KEY_PAUSE, 4);
        play_paused = 1'b1;
        repeat (2) wait_phase(4);
        press_key(KEY_PAUSE, 4);
        play_paused = 1'b0;
        wait_finish();
        assert (play_idx == exp_image.size())
            else value_mismatch("words played", exp_image.size(), play_idx);

        $display("Test completed successfully");
        $finish;
    end

endmodule
